//--- src/alu_pkg.sv
package alu_pkg;

    // datapath widths
    localparam int xlen   = 64;
    localparam int half_w = 32;

    // only the low six bits of operand b steer a shift
    localparam int shamt_w = 6;

    // multiplier sequencing
    localparam int mul_cycles = 32;
    localparam int mul_cnt_w  = $clog2(mul_cycles);
    localparam logic [mul_cnt_w-1:0] mul_last = mul_cnt_w'(mul_cycles - 1);

    // constants for the division corner cases
    localparam logic [xlen-1:0] int_min  = {1'b1, {(xlen-1){1'b0}}};
    localparam logic [xlen-1:0] all_ones = {xlen{1'b1}};

    // one code per operation
    typedef enum logic [4:0] {
        add    = 5'd0,
        sub    = 5'd1,
        ret_a  = 5'd2,
        ret_b  = 5'd3,
        xor_op = 5'd4,
        or_op  = 5'd5,
        and_op = 5'd6,
        sll    = 5'd7,
        srl    = 5'd8,
        sra    = 5'd9,
        slt    = 5'd10,
        sltu   = 5'd11,
        eq     = 5'd12,
        ge     = 5'd13,
        geu    = 5'd14,
        mul    = 5'd15,
        div    = 5'd16,
        divu   = 5'd17,
        rem    = 5'd18,
        remu   = 5'd19
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        sel_pc  = 2'd0,
        sel_rs1 = 2'd1
    } sel_a_e;

    // operand b source where unlisted codes fall back to imm
    typedef enum logic [1:0] {
        sel_imm = 2'd0,
        sel_rs2 = 2'd1,
        sel_csr = 2'd2
    } sel_b_e;

endpackage

//--- src/exec_pkg.sv
package exec_pkg;

    // one request to the execute stage held as a level
    typedef struct packed {
        alu_pkg::alu_op_e           op;
        alu_pkg::sel_a_e            sel_a;
        alu_pkg::sel_b_e            sel_b;
        // word form cuts rs1 to its low half
        logic                       word;
        logic [alu_pkg::xlen-1:0]   pc;
        logic [alu_pkg::xlen-1:0]   rs1;
        logic [alu_pkg::xlen-1:0]   rs2;
        logic [alu_pkg::xlen-1:0]   csr;
        logic [alu_pkg::xlen-1:0]   imm;
    } exec_req_t;

    // multiplier product as delivered
    typedef struct packed {
        logic [alu_pkg::half_w-1:0] hi;
        logic [alu_pkg::half_w-1:0] lo;
    } half_pair_t;

    // stage result as a full word or as the product halves
    typedef union packed {
        logic [alu_pkg::xlen-1:0]   dword;
        half_pair_t                 halves;
    } result_u;

endpackage

//--- src/alu_core.sv
`timescale 1ns/10ps

module alu_core (
    input  exec_pkg::exec_req_t          req,
    output logic [alu_pkg::xlen-1:0]     opa,
    output logic [alu_pkg::xlen-1:0]     opb,
    output logic [alu_pkg::xlen-1:0]     alu_res
);

    logic [alu_pkg::shamt_w-1:0]   shamt;
    logic signed [alu_pkg::xlen-1:0] sa;
    logic signed [alu_pkg::xlen-1:0] sb;
    logic [alu_pkg::xlen-1:0]      sra_d;
    logic [alu_pkg::half_w-1:0]    sra_w;
    logic [alu_pkg::xlen-1:0]      quot_s;
    logic [alu_pkg::xlen-1:0]      rem_s;
    logic [alu_pkg::xlen-1:0]      quot_u;
    logic [alu_pkg::xlen-1:0]      rem_u;
    logic                          div_zero;
    logic                          div_ovf;

    // operand a is the pc or rs1 with its low half zero-extended in word form
    always_comb begin
        if (req.sel_a == alu_pkg::sel_rs1) begin
            opa = req.word ? {{alu_pkg::half_w{1'b0}}, req.rs1[alu_pkg::half_w-1:0]}
                           : req.rs1;
        end else begin
            opa = req.pc;
        end
    end

    // operand b
    always_comb begin
        case (req.sel_b)
            alu_pkg::sel_rs2: opb = req.rs2;
            alu_pkg::sel_csr: opb = req.csr;
            default:          opb = req.imm;
        endcase
    end

    assign sa    = $signed(opa);
    assign sb    = $signed(opb);
    assign shamt = opb[alu_pkg::shamt_w-1:0];

    // arithmetic shifts kept apart so the sign survives
    assign sra_d = sa >>> shamt;
    assign sra_w = $signed(opa[alu_pkg::half_w-1:0]) >>> shamt;

    // raw quotients before the corner cases are patched
    assign div_zero = (opb == '0);
    assign div_ovf  = (opa == alu_pkg::int_min) && (opb == alu_pkg::all_ones);
    assign quot_s   = sa / sb;
    assign rem_s    = sa % sb;
    assign quot_u   = opa / opb;
    assign rem_u    = opa % opb;

    always_comb begin
        case (req.op)
            alu_pkg::add:    alu_res = opa + opb;
            alu_pkg::sub:    alu_res = opa - opb;
            alu_pkg::ret_a:  alu_res = opa;
            alu_pkg::ret_b:  alu_res = opb;
            alu_pkg::xor_op: alu_res = opa ^ opb;
            alu_pkg::or_op:  alu_res = opa | opb;
            alu_pkg::and_op: alu_res = opa & opb;
            alu_pkg::sll:    alu_res = opa << shamt;
            alu_pkg::srl:    alu_res = opa >> shamt;
            // word form zero-fills the upper half
            alu_pkg::sra: begin
                alu_res = req.word ? {{alu_pkg::half_w{1'b0}}, sra_w} : sra_d;
            end
            alu_pkg::slt:    alu_res = {{(alu_pkg::xlen-1){1'b0}}, sa < sb};
            alu_pkg::sltu:   alu_res = {{(alu_pkg::xlen-1){1'b0}}, opa < opb};
            alu_pkg::eq:     alu_res = {{(alu_pkg::xlen-1){1'b0}}, opa == opb};
            alu_pkg::ge:     alu_res = {{(alu_pkg::xlen-1){1'b0}}, sa >= sb};
            alu_pkg::geu:    alu_res = {{(alu_pkg::xlen-1){1'b0}}, opa >= opb};
            alu_pkg::div: begin
                if (div_zero) begin
                    alu_res = alu_pkg::all_ones;
                end else if (div_ovf) begin
                    alu_res = opa;
                end else begin
                    alu_res = quot_s;
                end
            end
            alu_pkg::rem: begin
                if (div_zero) begin
                    alu_res = opa;
                end else if (div_ovf) begin
                    alu_res = '0;
                end else begin
                    alu_res = rem_s;
                end
            end
            alu_pkg::divu:   alu_res = div_zero ? alu_pkg::all_ones : quot_u;
            alu_pkg::remu:   alu_res = div_zero ? opa : rem_u;
            // mul is produced by the sequential unit
            default:         alu_res = '0;
        endcase
    end

endmodule

//--- src/mul_seq.sv
`timescale 1ns/10ps

module mul_seq (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        start,
    input  logic [alu_pkg::half_w-1:0]  a,
    input  logic [alu_pkg::half_w-1:0]  b,
    output logic                        done,
    output logic [alu_pkg::half_w-1:0]  hi,
    output logic [alu_pkg::half_w-1:0]  lo
);

    logic                           running;
    logic [alu_pkg::mul_cnt_w-1:0]  cnt;
    logic [alu_pkg::half_w-1:0]     mcand;
    // upper half accumulates, lower half starts as the multiplier
    logic [2*alu_pkg::half_w-1:0]   prod;
    logic [alu_pkg::half_w:0]       sum;
    logic                           last;

    // add the multiplicand when the current multiplier bit is set
    assign sum = {1'b0, prod[2*alu_pkg::half_w-1:alu_pkg::half_w]}
               + (prod[0] ? {1'b0, mcand} : '0);

    assign last = (cnt == alu_pkg::mul_last);

    // operand capture and one shift-add step per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a;
            prod  <= {{alu_pkg::half_w{1'b0}}, b};
        end else if (running) begin
            prod <= {sum, prod[alu_pkg::half_w-1:1]};
        end
    end

    // iteration counter and done pulse
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // product is final in the cycle done is high
    assign hi = prod[2*alu_pkg::half_w-1:alu_pkg::half_w];
    assign lo = prod[alu_pkg::half_w-1:0];

endmodule

//--- src/exec_ctrl.sv
`timescale 1ns/10ps

module exec_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  alu_pkg::alu_op_e            op,
    input  logic [alu_pkg::xlen-1:0]    alu_res,
    input  logic                        done,
    input  logic [alu_pkg::half_w-1:0]  hi,
    input  logic [alu_pkg::half_w-1:0]  lo,
    output logic                        start,
    output logic                        busy,
    output exec_pkg::result_u           res
);

    logic mul_req;

    assign mul_req = (op == alu_pkg::mul);

    // busy and the start pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (flush) begin
                // abandon any multiply in flight
                busy <= 1'b0;
            end else if (busy) begin
                if (done) begin
                    busy <= 1'b0;
                end
            end else if (mul_req) begin
                busy  <= 1'b1;
                start <= 1'b1;
            end
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (rst) begin
            res.dword <= '0;
        end else if (flush) begin
            res <= res;
        end else if (busy) begin
            // held until the product arrives
            if (done) begin
                res.halves.hi <= hi;
                res.halves.lo <= lo;
            end
        end else if (!mul_req) begin
            res.dword <= alu_res;
        end
    end

endmodule

//--- src/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  exec_pkg::exec_req_t     req,
    output exec_pkg::result_u       res,
    output logic                    busy
);

    logic [alu_pkg::xlen-1:0]   opa;
    logic [alu_pkg::xlen-1:0]   opb;
    logic [alu_pkg::xlen-1:0]   alu_res;
    logic                       start;
    logic                       done;
    logic [alu_pkg::half_w-1:0] mul_hi;
    logic [alu_pkg::half_w-1:0] mul_lo;

    // operand select and single-cycle ops
    alu_core core0 (
        .req     (req),
        .opa     (opa),
        .opb     (opb),
        .alu_res (alu_res)
    );

    // multiply runs on the low operand halves
    mul_seq mul0 (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .start (start),
        .a     (opa[alu_pkg::half_w-1:0]),
        .b     (opb[alu_pkg::half_w-1:0]),
        .done  (done),
        .hi    (mul_hi),
        .lo    (mul_lo)
    );

    exec_ctrl ctrl0 (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .op      (req.op),
        .alu_res (alu_res),
        .done    (done),
        .hi      (mul_hi),
        .lo      (mul_lo),
        .start   (start),
        .busy    (busy),
        .res     (res)
    );

endmodule

//--- tests/exec_asserts.sv
`timescale 1ns/10ps

module exec_asserts (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              done,
    input logic              start,
    input logic              busy,
    input exec_pkg::result_u res
);

    // start is one cycle wide and only on the edge where busy rises
    start_pulse: assert property (@(posedge clk) disable iff (rst)
        start |-> busy && !$past(busy) && !$past(start))
        else $error("start pulsed outside a busy rise");

    // result frozen while a multiply runs
    res_hold: assert property (@(posedge clk) disable iff (rst)
        busy |-> $stable(res.dword))
        else $error("res changed while busy");

    busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> ($past(done) || $past(flush)))
        else $error("busy fell without done or flush");

endmodule

bind exec_ctrl exec_asserts asserts0 (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .done  (done),
    .start (start),
    .busy  (busy),
    .res   (res)
);

//--- tests/tb_exec_unit.sv
`timescale 1ns/10ps

module tb_exec_unit;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    // words per vector in the data file
    localparam int fields       = 11;
    localparam int max_vec      = 64;
    localparam logic [63:0] end_mark = 64'hff;
    // a multiply that runs longer than this is stuck
    localparam int mul_wait_limit = alu_pkg::mul_cycles + 8;

    logic                clk;
    logic                rst;
    logic                flush;
    exec_pkg::exec_req_t req;
    exec_pkg::result_u   res;
    logic                busy;

    logic [63:0]         vec_mem [0:max_vec*fields-1];
    int                  vec_count;
    bit                  loaded;
    int                  res_errors;
    int                  busy_errors;
    int                  other_errors;
    exec_pkg::result_u   last_res;

    exec_unit dut0 (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .req   (req),
        .res   (res),
        .busy  (busy)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_res(input exec_pkg::result_u exp, input exec_pkg::result_u got,
                             input int vec);
        if (got.dword !== exp.dword) begin
            res_errors++;
            $display("Error res expected %h got %h (vector %0d)", exp.dword, got.dword, vec);
        end
    endtask

    task automatic check_busy(input logic exp, input logic got, input int vec);
        if (got !== exp) begin
            busy_errors++;
            $display("Error busy expected %h got %h (vector %0d)", exp, got, vec);
        end
    endtask

    // unpack one line of the data file
    task automatic fetch_vector(input int idx, output logic [63:0] mode,
                                output exec_pkg::exec_req_t r, output exec_pkg::result_u exp);
        int base;
        base = idx * fields;
        r = '0;
        mode = vec_mem[base];
        r.op = alu_pkg::alu_op_e'(vec_mem[base+1][4:0]);
        r.sel_a = alu_pkg::sel_a_e'(vec_mem[base+2][1:0]);
        r.sel_b = alu_pkg::sel_b_e'(vec_mem[base+3][1:0]);
        r.word = vec_mem[base+4][0];
        r.pc = vec_mem[base+5];
        r.rs1 = vec_mem[base+6];
        r.rs2 = vec_mem[base+7];
        r.csr = vec_mem[base+8];
        r.imm = vec_mem[base+9];
        exp.dword = vec_mem[base+10];
    endtask

    // single-cycle op with the result visible after the sampling edge
    task automatic run_single(input exec_pkg::exec_req_t r, input exec_pkg::result_u exp,
                              input int vec);
        @(posedge clk);
        req <= r;
        @(posedge clk);
        @(negedge clk);
        check_busy(1'b0, busy, vec);
        check_res(exp, res, vec);
        last_res = exp;
    endtask

    task automatic run_mul(input exec_pkg::exec_req_t r, input exec_pkg::result_u exp,
                           input logic [63:0] mode, input int vec);
        int                  waited;
        exec_pkg::exec_req_t idle;
        idle = '0;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        @(negedge clk);
        check_busy(1'b1, busy, vec);
        if (mode != 0) begin
            // abort partway through and expect the old result to survive
            repeat (mode) begin
                check_res(last_res, res, vec);
                @(negedge clk);
            end
            @(posedge clk);
            flush <= 1'b1;
            req <= idle;
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            check_busy(1'b0, busy, vec);
            check_res(exp, res, vec);
            // aborted multiplier stays silent
            repeat (alu_pkg::mul_cycles + 2) begin
                if (dut0.done) begin
                    other_errors++;
                    $display("multiplier signalled done after a flush (vector %0d)", vec);
                end
                @(negedge clk);
            end
        end else begin
            waited = 0;
            while (!dut0.done && waited < mul_wait_limit) begin
                check_res(last_res, res, vec);
                @(negedge clk);
                waited++;
            end
            if (!dut0.done) begin
                other_errors++;
                $display("multiply never finished, busy stayed high (vector %0d)", vec);
                // abandon it so later vectors still run
                @(posedge clk);
                flush <= 1'b1;
                req <= idle;
                @(posedge clk);
                flush <= 1'b0;
            end else begin
                // drop the request on the edge that ends the run
                @(posedge clk);
                req <= idle;
                @(negedge clk);
                check_busy(1'b0, busy, vec);
                check_res(exp, res, vec);
            end
        end
        // idle request adds a zero pc to a zero imm
        last_res = '0;
    endtask

    initial begin
        exec_pkg::exec_req_t r;
        exec_pkg::result_u   exp;
        exec_pkg::result_u   zero_res;
        logic [63:0]         mode;
        int                  i;
        clk = 1'b0;
        rst <= 1'b1;
        flush <= 1'b0;
        req <= '0;
        res_errors = 0;
        busy_errors = 0;
        other_errors = 0;
        last_res = '0;
        zero_res = '0;
        $readmemh("tests/exec_testdata.hex", vec_mem);
        vec_count = 0;
        while (vec_count < max_vec && vec_mem[vec_count*fields] != end_mark) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            other_errors++;
            $display("no test vectors found in the data file");
        end
        loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // reset state before any request
        check_busy(1'b0, busy, -1);
        check_res(zero_res, res, -1);

        for (i = 0; i < vec_count; i++) begin
            fetch_vector(i, mode, r, exp);
            if (r.op == alu_pkg::mul) begin
                run_mul(r, exp, mode, i);
            end else begin
                run_single(r, exp, i);
            end
        end

        $display("errors: res %0d busy %0d other %0d", res_errors, busy_errors, other_errors);
        if (res_errors + busy_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized for every vector being a full multiply
    initial begin
        wait (loaded);
        #((reset_cycles + (vec_count + 1) * (alu_pkg::mul_cycles + 4)) * clk_period);
        $display("watchdog expired before the %0d vectors finished", vec_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- tests/exec_testdata.hex
// columns: mode op sel_a sel_b word pc rs1 rs2 csr imm expected
// mode 0 runs the op, mode n flushes a multiply n cycles in, mode ff ends the list
0 0 0 0 0 1000 0 0 0 24 1024
0 0 1 1 0 0 7fffffffffffffff 1 0 0 8000000000000000
0 1 1 1 0 0 5 7 0 0 fffffffffffffffe
0 2 0 0 0 deadbeef00000000 0 0 0 5 deadbeef00000000
0 3 1 2 0 0 0 0 0123456789abcdef 0 0123456789abcdef
0 0 1 0 1 0 ffffffff80000000 0 0 1 80000001
0 2 1 0 1 0 123456789abcdef0 0 0 0 9abcdef0
0 4 1 1 0 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 f0f0f0f0f0f0f0f0
0 5 1 2 0 0 00000000ffff0000 0 f000000000000f0f 0 f0000000ffff0f0f
0 6 0 0 0 ffff0000ffff0000 0 0 0 0f0f0f0f0f0f0f0f 0f0f00000f0f0000
0 a 1 1 0 0 ffffffffffffffff 1 0 0 1
0 b 1 1 0 0 ffffffffffffffff 1 0 0 0
0 c 1 2 0 0 abcd 0 abcd 0 1
0 c 0 2 0 5 0 0 6 0 0
0 d 1 1 0 0 ffffffffffffffff 1 0 0 0
0 d 1 0 0 0 5 0 0 5 1
0 e 1 1 0 0 ffffffffffffffff 1 0 0 1
0 7 1 0 0 0 1 0 0 3f 8000000000000000
0 7 1 0 0 0 1 0 0 40 1
0 7 1 1 0 0 3 ff 0 0 8000000000000000
0 8 1 0 0 0 8000000000000000 0 0 7f 1
0 8 1 0 1 0 ffffffff80000000 0 0 4 8000000
0 9 1 0 0 0 8000000000000000 0 0 3c fffffffffffffff8
0 9 1 0 1 0 ffffffff80000000 0 0 4 f8000000
0 9 1 0 0 0 7000000000000000 0 0 4 0700000000000000
0 10 1 1 0 0 fffffffffffffff9 2 0 0 fffffffffffffffd
0 12 1 1 0 0 fffffffffffffff9 2 0 0 ffffffffffffffff
0 11 1 1 0 0 64 7 0 0 e
0 13 1 1 0 0 64 7 0 0 2
0 10 1 1 0 0 1234 0 0 0 ffffffffffffffff
0 11 1 1 0 0 1234 0 0 0 ffffffffffffffff
0 12 1 1 0 0 1234 0 0 0 1234
0 13 1 1 0 0 1234 0 0 0 1234
0 12 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0
0 10 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000
0 f 1 1 0 0 ffffffff12345678 10 0 0 123456780
0 f 0 0 0 ffffffff 0 0 0 abcdef00ffffffff fffffffe00000001
0 0 1 2 0 0 10 0 20 0 30
5 f 1 1 0 0 3 5 0 0 30
0 1 0 0 0 100 0 0 0 1 ff
0 f 1 1 1 0 ffffffff00000003 5 0 0 f
0 3 1 1 0 0 0 cafe 0 0 cafe
ff 0 0 0 0 0 0 0 0 0 0

//--- files.f
src/alu_pkg.sv
src/exec_pkg.sv
src/alu_core.sv
src/mul_seq.sv
src/exec_ctrl.sv
src/exec_unit.sv
tests/exec_asserts.sv
tests/tb_exec_unit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec_unit -f files.f

out=$(./obj_dir/Vtb_exec_unit)
echo "$out"

echo "$out" | grep -qx "RESULT: PASS"
